//--- cpu_pkg.sv
package cpu_pkg;

   // Machine word and RAM geometry
   localparam int DATA_WIDTH     = 32;
   localparam int RAM_ADDR_WIDTH = 10;

   // Host register offsets on the Wishbone port
   localparam logic [3:0] REG_CTRL    = 4'h0;
   localparam logic [3:0] REG_STATUS  = 4'h4;
   localparam logic [3:0] REG_PC      = 4'h8;
   localparam logic [3:0] REG_RETIRED = 4'hc;

   // Address bit that selects the RAM window instead of the registers
   localparam int MEM_WINDOW_BIT = 14;

   // Core phase
   typedef enum logic [1:0] {
      FETCH   = 2'd0,
      EXECUTE = 2'd1
   } phase_e;

   // RV32I major opcodes of the supported subset
   typedef enum logic [6:0] {
      OP_LUI    = 7'b0110111,
      OP_IMM    = 7'b0010011,
      OP_REG    = 7'b0110011,
      OP_LOAD   = 7'b0000011,
      OP_STORE  = 7'b0100011,
      OP_BRANCH = 7'b1100011,
      OP_JAL    = 7'b1101111
   } opcode_e;

endpackage

//--- fetch.sv
`timescale 1ns/10ps

module fetch
   import cpu_pkg::*;
(
   input  logic                  i_clk,
   input  logic                  i_rst,

   input  logic [31:0]           i_pc,

   output logic [31:0]           o_mem_addr,
   input  logic [DATA_WIDTH-1:0] i_mem_data,

   output logic [31:0]           o_inst,
   output logic                  o_started,
   output logic                  o_ready
);

   logic step;

   // PC goes straight to the memory port
   assign o_mem_addr = i_pc;

   // Step is low in the address cycle and high in the data cycle
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         step <= 1'b0;
      end else begin
         step <= 1'b1;
      end
   end

   assign o_started = !i_rst && !step;

   // RAM output is valid one cycle after the address
   assign o_ready = !i_rst && step;

   // Instruction is held through the execute phase
   always_ff @(posedge i_clk) begin
      if (!i_rst && step) begin
         o_inst <= i_mem_data;
      end
   end

endmodule

//--- regfile.sv
`timescale 1ns/10ps

module regfile (
   input  logic        i_clk,
   input  logic        i_rst,

   input  logic [4:0]  i_rs1,
   input  logic [4:0]  i_rs2,
   output logic [31:0] o_rs1_data,
   output logic [31:0] o_rs2_data,

   input  logic        i_we,
   input  logic [4:0]  i_rd,
   input  logic [31:0] i_rd_data
);

   logic [31:0] regs [32];

   // x0 reads as zero whatever the array holds
   assign o_rs1_data = (i_rs1 == 5'd0) ? 32'd0 : regs[i_rs1];
   assign o_rs2_data = (i_rs2 == 5'd0) ? 32'd0 : regs[i_rs2];

   // Writes are blocked while the unit is held in reset
   always_ff @(posedge i_clk) begin
      if (!i_rst && i_we && i_rd != 5'd0) begin
         regs[i_rd] <= i_rd_data;
      end
   end

endmodule

//--- execute.sv
`timescale 1ns/10ps

module execute
   import cpu_pkg::*;
(
   input  logic                  i_clk,
   input  logic                  i_rst,

   input  logic [31:0]           i_inst,
   input  logic [31:0]           i_pc,

   output logic [31:0]           o_mem_addr,
   input  logic [DATA_WIDTH-1:0] i_mem_data,
   output logic                  o_mem_write,
   output logic [DATA_WIDTH-1:0] o_mem_data,

   output logic                  o_pc_change,
   output logic [31:0]           o_new_pc,
   output logic                  o_ready,
   output logic                  o_invalid_inst
);

   opcode_e     opcode;
   logic [2:0]  funct3;
   logic [6:0]  funct7;
   logic [4:0]  rs1;
   logic [4:0]  rs2;
   logic [4:0]  rd;
   logic [31:0] imm_i;
   logic [31:0] imm_s;
   logic [31:0] imm_b;
   logic [31:0] imm_j;
   logic [31:0] imm_u;
   logic [31:0] rs1_data;
   logic [31:0] rs2_data;
   logic [31:0] alu_b;
   logic [31:0] alu_result;
   logic [31:0] rd_data;
   logic        alu_f3_ok;
   logic        valid;
   logic        rd_write;
   logic        is_load;
   logic        load_step;
   logic        branch_taken;

   assign opcode = opcode_e'(i_inst[6:0]);
   assign funct3 = i_inst[14:12];
   assign funct7 = i_inst[31:25];
   assign rs1    = i_inst[19:15];
   assign rs2    = i_inst[24:20];
   assign rd     = i_inst[11:7];

   assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
   assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
   assign imm_b = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
   assign imm_j = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
   assign imm_u = {i_inst[31:12], 12'd0};

   // ADD, SLT, XOR, OR, AND share funct3 between the I and R forms
   assign alu_f3_ok = funct3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111};

   // Decode and legality check
   always_comb begin
      valid    = 1'b0;
      rd_write = 1'b0;
      is_load  = 1'b0;
      case (opcode)
         OP_LUI: begin
            valid    = 1'b1;
            rd_write = 1'b1;
         end
         OP_IMM: begin
            valid    = alu_f3_ok;
            rd_write = 1'b1;
         end
         OP_REG: begin
            valid    = (funct7 == 7'b0000000 && alu_f3_ok) ||
                       (funct7 == 7'b0100000 && funct3 == 3'b000);
            rd_write = 1'b1;
         end
         OP_LOAD: begin
            valid    = funct3 == 3'b010;
            rd_write = 1'b1;
            is_load  = 1'b1;
         end
         OP_STORE:  valid = funct3 == 3'b010;
         // BEQ and BNE only
         OP_BRANCH: valid = funct3[2:1] == 2'b00;
         OP_JAL: begin
            valid    = 1'b1;
            rd_write = 1'b1;
         end
         default: valid = 1'b0;
      endcase
   end

   // ALU
   assign alu_b = (opcode == OP_REG) ? rs2_data : imm_i;

   always_comb begin
      case (funct3)
         3'b000: alu_result = (opcode == OP_REG && funct7[5]) ? rs1_data - alu_b
                                                               : rs1_data + alu_b;
         3'b010: alu_result = {31'd0, $signed(rs1_data) < $signed(alu_b)};
         3'b100: alu_result = rs1_data ^ alu_b;
         3'b110: alu_result = rs1_data | alu_b;
         default: alu_result = rs1_data & alu_b;
      endcase
   end

   always_comb begin
      case (opcode)
         OP_LUI:  rd_data = imm_u;
         OP_LOAD: rd_data = i_mem_data;
         OP_JAL:  rd_data = i_pc + 32'd4;
         default: rd_data = alu_result;
      endcase
   end

   // Load and store share one address adder
   assign o_mem_addr  = rs1_data + ((opcode == OP_STORE) ? imm_s : imm_i);
   assign o_mem_data  = rs2_data;
   assign o_mem_write = valid && opcode == OP_STORE;

   // funct3 bit 0 flips BEQ into BNE
   assign branch_taken = (rs1_data == rs2_data) ^ funct3[0];
   assign o_pc_change  = valid && ((opcode == OP_BRANCH && branch_taken) || opcode == OP_JAL);
   assign o_new_pc     = i_pc + ((opcode == OP_JAL) ? imm_j : imm_b);

   // LW spends its first cycle on the address
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         load_step <= 1'b0;
      end else if (valid && is_load) begin
         load_step <= 1'b1;
      end
   end

   assign o_ready        = valid && (!is_load || load_step);
   assign o_invalid_inst = !valid;

   regfile regfile_i (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_rs1      (rs1),
      .i_rs2      (rs2),
      .o_rs1_data (rs1_data),
      .o_rs2_data (rs2_data),
      .i_we       (o_ready && rd_write),
      .i_rd       (rd),
      .i_rd_data  (rd_data)
   );

   a_ready_xor_invalid: assert property (@(posedge i_clk) disable iff (i_rst)
      !(o_ready && o_invalid_inst))
      else $error("execute reports ready on an invalid instruction");

endmodule

//--- core.sv
`timescale 1ns/10ps

module core
   import cpu_pkg::*;
(
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  logic                  i_run,

   output logic [31:0]           o_mem_addr,
   output logic [DATA_WIDTH-1:0] o_mem_data,
   input  logic [DATA_WIDTH-1:0] i_mem_data,
   output logic                  o_mem_write,

   output logic [31:0]           o_pc,
   output logic                  o_retire,
   output logic                  o_halted
);

   phase_e                phase;
   logic [31:0]           pc;
   logic [31:0]           inst;
   logic                  core_rst;

   logic                  fetch_rst;
   logic                  fetch_started;
   logic                  fetch_ready;
   logic [31:0]           fetch_mem_addr;
   logic [DATA_WIDTH-1:0] fetch_mem_in;

   logic                  execute_rst;
   logic                  execute_ready;
   logic                  invalid_inst;
   logic                  pc_change;
   logic [31:0]           new_pc;
   logic [31:0]           execute_mem_addr;
   logic [DATA_WIDTH-1:0] execute_mem_in;
   logic [DATA_WIDTH-1:0] execute_mem_out;
   logic                  execute_mem_write;

   // Run bit low holds the whole core at PC 0
   assign core_rst    = i_rst || !i_run;
   assign fetch_rst   = core_rst || phase != FETCH;
   assign execute_rst = core_rst || phase != EXECUTE;

   always_ff @(posedge i_clk) begin
      if (core_rst) begin
         phase    <= FETCH;
         pc       <= 32'd0;
         o_halted <= 1'b0;
      end else begin
         case (phase)
            FETCH: begin
               if (fetch_ready) begin
                  phase <= EXECUTE;
               end
            end
            EXECUTE: begin
               // Invalid opcode parks the core in EXECUTE with the PC unchanged
               if (invalid_inst) begin
                  o_halted <= 1'b1;
               end else if (execute_ready) begin
                  phase <= FETCH;
                  pc    <= pc_change ? new_pc : pc + 32'd4;
               end
            end
            default: phase <= FETCH;
         endcase
      end
   end

   assign o_pc     = pc;
   assign o_retire = phase == EXECUTE && execute_ready;

   // Memory port belongs to the unit of the current phase
   always_comb begin
      if (phase == EXECUTE) begin
         fetch_mem_in   = '0;
         execute_mem_in = i_mem_data;
         o_mem_addr     = execute_mem_addr;
         o_mem_data     = execute_mem_out;
         o_mem_write    = execute_mem_write;
      end else begin
         fetch_mem_in   = i_mem_data;
         execute_mem_in = '0;
         o_mem_addr     = fetch_mem_addr;
         o_mem_data     = '0;
         o_mem_write    = 1'b0;
      end
   end

   fetch fetch_i (
      .i_clk      (i_clk),
      .i_rst      (fetch_rst),
      .i_pc       (pc),
      .o_mem_addr (fetch_mem_addr),
      .i_mem_data (fetch_mem_in),
      .o_inst     (inst),
      .o_started  (fetch_started),
      .o_ready    (fetch_ready)
   );

   execute execute_i (
      .i_clk          (i_clk),
      .i_rst          (execute_rst),
      .i_inst         (inst),
      .i_pc           (pc),
      .o_mem_addr     (execute_mem_addr),
      .i_mem_data     (execute_mem_in),
      .o_mem_write    (execute_mem_write),
      .o_mem_data     (execute_mem_out),
      .o_pc_change    (pc_change),
      .o_new_pc       (new_pc),
      .o_ready        (execute_ready),
      .o_invalid_inst (invalid_inst)
   );

   a_no_write_in_fetch: assert property (@(posedge i_clk) disable iff (core_rst)
      phase == FETCH |-> !o_mem_write)
      else $error("memory write during fetch");

   // Fetch reports the word only after it has issued the address
   a_fetch_order: assert property (@(posedge i_clk) disable iff (fetch_rst)
      fetch_ready |-> $past(fetch_started))
      else $error("fetch ready without a started address cycle");

endmodule

//--- dual_port_ram.sv
`timescale 1ns/10ps

module dual_port_ram #(
   parameter int DATA_WIDTH     = 32,
   parameter int RAM_ADDR_WIDTH = 10
) (
   input  logic                      i_clk,

   input  logic [RAM_ADDR_WIDTH-1:0] i_addr_a,
   input  logic [DATA_WIDTH-1:0]     i_data_a,
   input  logic                      i_write_a,
   output logic [DATA_WIDTH-1:0]     o_data_a,

   input  logic [RAM_ADDR_WIDTH-1:0] i_addr_b,
   input  logic [DATA_WIDTH-1:0]     i_data_b,
   input  logic                      i_write_b,
   output logic [DATA_WIDTH-1:0]     o_data_b
);

   logic [DATA_WIDTH-1:0] mem [2**RAM_ADDR_WIDTH];

   // Read-first on both ports
   always_ff @(posedge i_clk) begin
      o_data_a <= mem[i_addr_a];
      o_data_b <= mem[i_addr_b];
      if (i_write_b) begin
         mem[i_addr_b] <= i_data_b;
      end
      // Port A last, so it wins a same-word collision
      if (i_write_a) begin
         mem[i_addr_a] <= i_data_a;
      end
   end

endmodule

//--- host_regs.sv
`timescale 1ns/10ps

module host_regs
   import cpu_pkg::*;
(
   input  logic                      i_clk,
   input  logic                      i_rst,

   input  logic                      i_wb_cyc,
   input  logic                      i_wb_stb,
   input  logic                      i_wb_we,
   input  logic [31:0]               i_wb_adr,
   input  logic [DATA_WIDTH-1:0]     i_wb_dat,
   output logic [DATA_WIDTH-1:0]     o_wb_dat,
   output logic                      o_wb_ack,

   output logic                      o_run,
   input  logic                      i_halted,
   input  logic                      i_retire,
   input  logic [31:0]               i_pc,

   output logic [RAM_ADDR_WIDTH-1:0] o_ram_addr,
   output logic [DATA_WIDTH-1:0]     o_ram_data,
   output logic                      o_ram_write,
   input  logic [DATA_WIDTH-1:0]     i_ram_data
);

   logic                  sel_mem;
   logic                  reg_write;
   logic [DATA_WIDTH-1:0] retired;
   logic [DATA_WIDTH-1:0] reg_rdata;

   assign sel_mem = i_wb_adr[MEM_WINDOW_BIT];

   // RAM address is presented at once, so read data is ready with the ack
   assign o_ram_addr  = i_wb_adr[RAM_ADDR_WIDTH+1:2];
   assign o_ram_data  = i_wb_dat;
   assign o_ram_write = o_wb_ack && i_wb_we && sel_mem;
   assign reg_write   = o_wb_ack && i_wb_we && !sel_mem;

   // Single-cycle ack, one clock after the request
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_wb_ack <= 1'b0;
      end else begin
         o_wb_ack <= i_wb_cyc && i_wb_stb && !o_wb_ack;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_run <= 1'b0;
      end else if (reg_write && i_wb_adr[3:0] == REG_CTRL) begin
         o_run <= i_wb_dat[0];
      end
   end

   // Retired count restarts with each run
   always_ff @(posedge i_clk) begin
      if (i_rst || !o_run) begin
         retired <= '0;
      end else if (i_retire) begin
         retired <= retired + 1'b1;
      end
   end

   always_comb begin
      case (i_wb_adr[3:0])
         REG_CTRL:    reg_rdata = {{(DATA_WIDTH-1){1'b0}}, o_run};
         REG_STATUS:  reg_rdata = {{(DATA_WIDTH-1){1'b0}}, i_halted};
         REG_PC:      reg_rdata = i_pc;
         REG_RETIRED: reg_rdata = retired;
         default:     reg_rdata = '0;
      endcase
   end

   assign o_wb_dat = sel_mem ? i_ram_data : reg_rdata;

   a_ack_single: assert property (@(posedge i_clk) disable iff (i_rst)
      o_wb_ack |=> !o_wb_ack)
      else $error("Wishbone ack held for two cycles");

endmodule

//--- cpu_top.sv
`timescale 1ns/10ps

module cpu_top #(
   parameter int DATA_WIDTH     = cpu_pkg::DATA_WIDTH,
   parameter int RAM_ADDR_WIDTH = cpu_pkg::RAM_ADDR_WIDTH
) (
   input  logic                  i_clk,
   input  logic                  i_rst,

   input  logic                  i_wb_cyc,
   input  logic                  i_wb_stb,
   input  logic                  i_wb_we,
   input  logic [31:0]           i_wb_adr,
   input  logic [DATA_WIDTH-1:0] i_wb_dat,
   output logic [DATA_WIDTH-1:0] o_wb_dat,
   output logic                  o_wb_ack
);

   logic [31:0]               core_mem_addr;
   logic [DATA_WIDTH-1:0]     core_mem_wdata;
   logic [DATA_WIDTH-1:0]     core_mem_rdata;
   logic                      core_mem_write;
   logic [31:0]               core_pc;
   logic                      core_retire;
   logic                      core_halted;
   logic                      run;

   logic [RAM_ADDR_WIDTH-1:0] host_ram_addr;
   logic [DATA_WIDTH-1:0]     host_ram_wdata;
   logic [DATA_WIDTH-1:0]     host_ram_rdata;
   logic                      host_ram_write;

   core core_i (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_run       (run),
      .o_mem_addr  (core_mem_addr),
      .o_mem_data  (core_mem_wdata),
      .i_mem_data  (core_mem_rdata),
      .o_mem_write (core_mem_write),
      .o_pc        (core_pc),
      .o_retire    (core_retire),
      .o_halted    (core_halted)
   );

   // Core byte address to RAM word address
   dual_port_ram #(
      .DATA_WIDTH     (DATA_WIDTH),
      .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
   ) ram_i (
      .i_clk     (i_clk),
      .i_addr_a  (core_mem_addr[RAM_ADDR_WIDTH+1:2]),
      .i_data_a  (core_mem_wdata),
      .i_write_a (core_mem_write),
      .o_data_a  (core_mem_rdata),
      .i_addr_b  (host_ram_addr),
      .i_data_b  (host_ram_wdata),
      .i_write_b (host_ram_write),
      .o_data_b  (host_ram_rdata)
   );

   host_regs host_regs_i (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_wb_cyc    (i_wb_cyc),
      .i_wb_stb    (i_wb_stb),
      .i_wb_we     (i_wb_we),
      .i_wb_adr    (i_wb_adr),
      .i_wb_dat    (i_wb_dat),
      .o_wb_dat    (o_wb_dat),
      .o_wb_ack    (o_wb_ack),
      .o_run       (run),
      .i_halted    (core_halted),
      .i_retire    (core_retire),
      .i_pc        (core_pc),
      .o_ram_addr  (host_ram_addr),
      .o_ram_data  (host_ram_wdata),
      .o_ram_write (host_ram_write),
      .i_ram_data  (host_ram_rdata)
   );

endmodule

//--- tb_clkgen.sv
`timescale 1ns/10ps

module tb_clkgen #(
   parameter int PERIOD_NS    = 100,
   parameter int RESET_CYCLES = 2
) (
   output logic o_clk,
   output logic o_rst
);

   initial begin
      o_clk = 1'b0;
      forever #(PERIOD_NS / 2) o_clk = ~o_clk;
   end

   // Reset released on a falling edge, away from the sampling edge
   initial begin
      o_rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge o_clk);
      @(negedge o_clk);
      o_rst = 1'b0;
   end

endmodule

//--- tb_checker.sv
`timescale 1ns/10ps

module tb_checker #(
   parameter int ADDR_WIDTH = 10,
   parameter int STEP_LIMIT = 5000
) (
   input  logic        i_clk,
   input  logic        i_rst,
   input  logic        i_wb_cyc,
   input  logic        i_wb_stb,
   input  logic        i_wb_we,
   input  logic [31:0] i_wb_adr,
   input  logic [31:0] i_wb_dat,
   input  logic [31:0] i_wb_rdat,
   input  logic        i_wb_ack,
   output int          o_errors
);

   // Shadow of the RAM, updated by host writes and by the model's stores
   logic [31:0] mem_model [2**ADDR_WIDTH];
   logic        run;
   logic [31:0] exp_pc;
   logic [31:0] exp_retired;
   int          model_count;

   initial o_errors = 0;

   // Interprets the RV32I subset from PC 0 up to the first invalid word
   function automatic void run_model(output logic [31:0] pc_out, output int count_out);
      logic [31:0] rf [32];
      logic [31:0] pc;
      logic [31:0] next_pc;
      logic [31:0] inst;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm_i;
      logic [31:0] imm_s;
      logic [31:0] res;
      logic [6:0]  op;
      logic [6:0]  f7;
      logic [2:0]  f3;
      logic        legal;
      logic        wr;
      int          steps;
      for (int r = 0; r < 32; r++) begin
         rf[r] = 32'd0;
      end
      pc        = 32'd0;
      count_out = 0;
      steps     = 0;
      legal     = 1'b1;
      while (legal && steps < STEP_LIMIT) begin
         inst    = mem_model[pc[ADDR_WIDTH+1:2]];
         op      = inst[6:0];
         f3      = inst[14:12];
         f7      = inst[31:25];
         a       = rf[inst[19:15]];
         b       = rf[inst[24:20]];
         imm_i   = {{20{inst[31]}}, inst[31:20]};
         imm_s   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
         next_pc = pc + 32'd4;
         wr      = 1'b0;
         res     = 32'd0;
         case (op)
            7'b0110111: begin
               res = {inst[31:12], 12'd0};
               wr  = 1'b1;
            end
            7'b0010011, 7'b0110011: begin
               if (op == 7'b0110011) begin
                  legal = (f7 == 7'h00 && f3 inside {0, 2, 4, 6, 7}) ||
                          (f7 == 7'h20 && f3 == 3'd0);
               end else begin
                  legal = f3 inside {0, 2, 4, 6, 7};
                  b     = imm_i;
               end
               case (f3)
                  3'd0: res = (op == 7'b0110011 && f7 == 7'h20) ? a - b : a + b;
                  3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  3'd4: res = a ^ b;
                  3'd6: res = a | b;
                  default: res = a & b;
               endcase
               wr = 1'b1;
            end
            7'b0000011: begin
               legal = f3 == 3'd2;
               res   = mem_model[(a + imm_i) >> 2];
               wr    = 1'b1;
            end
            7'b0100011: begin
               legal = f3 == 3'd2;
               if (legal) begin
                  mem_model[(a + imm_s) >> 2] = b;
               end
            end
            7'b1100011: begin
               legal = f3 == 3'd0 || f3 == 3'd1;
               if ((a == b) == (f3 == 3'd0)) begin
                  next_pc = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
               end
            end
            7'b1101111: begin
               res     = pc + 32'd4;
               wr      = 1'b1;
               next_pc = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: legal = 1'b0;
         endcase
         if (legal) begin
            if (wr && inst[11:7] != 5'd0) begin
               rf[inst[11:7]] = res;
            end
            pc        = next_pc;
            count_out = count_out + 1;
         end
         steps++;
      end
      if (legal) begin
         $display("Reference model found no invalid instruction within %0d steps", steps);
         o_errors++;
      end
      pc_out = pc;
   endfunction

   task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s addr 0x%08h read 0x%08h expected 0x%08h",
                  $time, what, i_wb_adr, got, exp);
         o_errors++;
      end
   endtask

   // Bus sampled on the rising edge, where the falling-edge stimulus is stable
   always @(posedge i_clk) begin
      if (i_rst) begin
         run         = 1'b0;
         exp_pc      = 32'd0;
         exp_retired = 32'd0;
      end else if (i_wb_cyc && i_wb_stb && i_wb_ack) begin
         if (i_wb_we) begin
            if (i_wb_adr[14]) begin
               mem_model[i_wb_adr[ADDR_WIDTH+1:2]] = i_wb_dat;
            end else if (i_wb_adr[3:0] == 4'h0) begin
               run = i_wb_dat[0];
               if (run) begin
                  run_model(exp_pc, model_count);
                  exp_retired = model_count;
               end else begin
                  exp_pc      = 32'd0;
                  exp_retired = 32'd0;
               end
            end
         end else if (i_wb_adr[14]) begin
            compare("RAM", i_wb_rdat, mem_model[i_wb_adr[ADDR_WIDTH+1:2]]);
         end else begin
            case (i_wb_adr[3:0])
               4'h0: compare("CTRL", i_wb_rdat, {31'd0, run});
               // STATUS is polled while running, so only the idle value is fixed
               4'h4: if (!run) compare("STATUS", i_wb_rdat, 32'd0);
               4'h8: compare("PC", i_wb_rdat, exp_pc);
               4'hc: compare("RETIRED", i_wb_rdat, exp_retired);
               default: compare("unmapped", i_wb_rdat, 32'd0);
            endcase
         end
      end
   end

endmodule

//--- tb_top.sv
`timescale 1ns/10ps

module tb_top;

   localparam logic [31:0] RAM_BASE = 32'h0000_4000;
   localparam int ACK_TIMEOUT  = 20;
   localparam int HALT_TIMEOUT = 600;
   localparam int RST_TIMEOUT  = 10;

   logic        clk;
   logic        rst;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   logic [31:0] wb_adr;
   logic [31:0] wb_dat_w;
   logic [31:0] wb_dat_r;
   logic        wb_ack;
   int          check_errors;
   int          host_errors;
   logic [31:0] prog [$];
   logic [31:0] rdata;
   int          n;

   tb_clkgen #(.PERIOD_NS(100), .RESET_CYCLES(2)) clkgen_i (.o_clk(clk), .o_rst(rst));

   cpu_top cpu_top_i (
      .i_clk    (clk),
      .i_rst    (rst),
      .i_wb_cyc (wb_cyc),
      .i_wb_stb (wb_stb),
      .i_wb_we  (wb_we),
      .i_wb_adr (wb_adr),
      .i_wb_dat (wb_dat_w),
      .o_wb_dat (wb_dat_r),
      .o_wb_ack (wb_ack)
   );

   tb_checker #(.ADDR_WIDTH(10)) monitor_i (
      .i_clk     (clk),
      .i_rst     (rst),
      .i_wb_cyc  (wb_cyc),
      .i_wb_stb  (wb_stb),
      .i_wb_we   (wb_we),
      .i_wb_adr  (wb_adr),
      .i_wb_dat  (wb_dat_w),
      .i_wb_rdat (wb_dat_r),
      .i_wb_ack  (wb_ack),
      .o_errors  (check_errors)
   );

   // Instruction encoders
   function automatic logic [31:0] itype(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                         logic [11:0] imm, logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] rtype(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                         logic [4:0] rs1, logic [4:0] rs2);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] stype(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] btype(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                         logic [12:0] off);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] jtype(logic [4:0] rd, logic [20:0] off);
      return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
   endfunction

   task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
      int cnt;
      @(negedge clk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdat;
      cnt      = 0;
      do begin
         @(negedge clk);
         cnt++;
      end while (!wb_ack && cnt < ACK_TIMEOUT);
      if (!wb_ack) begin
         $display("Timeout: no Wishbone ack for address 0x%08h", adr);
         host_errors++;
      end
      rdat = wb_dat_r;
      // Hold through the ack edge, then release
      @(negedge clk);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic write_word(input logic [31:0] adr, input logic [31:0] data);
      logic [31:0] unused;
      bus_cycle(1'b1, adr, data, unused);
   endtask

   task automatic read_word(input logic [31:0] adr, output logic [31:0] data);
      bus_cycle(1'b0, adr, 32'd0, data);
   endtask

   task automatic load_program();
      for (int i = 0; i < prog.size(); i++) begin
         write_word(RAM_BASE + 4 * i, prog[i]);
      end
   endtask

   task automatic wait_for_halt();
      logic [31:0] status;
      int cnt;
      cnt = 0;
      do begin
         read_word(32'h4, status);
         cnt++;
      end while (!status[0] && cnt < HALT_TIMEOUT);
      if (!status[0]) begin
         $display("Timeout: core did not halt");
         host_errors++;
      end
   endtask

   // Start, wait for the halt, read PC and RETIRED
   task automatic run_and_report();
      logic [31:0] d;
      write_word(32'h0, 32'd1);
      wait_for_halt();
      read_word(32'h8, d);
      read_word(32'hc, d);
   endtask

   initial begin
      logic [2:0] f3_list [5];
      int         sel;
      f3_list     = '{3'd0, 3'd2, 3'd4, 3'd6, 3'd7};
      host_errors = 0;
      wb_cyc      = 1'b0;
      wb_stb      = 1'b0;
      wb_we       = 1'b0;
      wb_adr      = 32'd0;
      wb_dat_w    = 32'd0;
      void'($urandom(32'hfabf));
      n = 0;
      while (rst && n < RST_TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (rst) begin
         $display("Timeout: reset never released");
         host_errors++;
      end

      // Reset values and RAM window round trip
      for (int a = 0; a < 16; a += 4) begin
         read_word(a, rdata);
      end
      write_word(RAM_BASE + 32'hff0, $urandom);
      read_word(RAM_BASE + 32'hff0, rdata);

      // Random straight-line program
      prog.delete();
      for (int r = 1; r < 8; r++) begin
         prog.push_back(itype(3'd0, r[4:0], 5'd0, 12'($urandom), 7'b0010011));
      end
      for (int i = 0; i < 24; i++) begin
         sel = $urandom % 3;
         if (sel == 0) begin
            prog.push_back(itype(f3_list[$urandom % 5], 5'd1 + 5'($urandom % 7),
                                 5'd1 + 5'($urandom % 7), 12'($urandom), 7'b0010011));
         end else if (sel == 1) begin
            prog.push_back({20'($urandom), 5'd1 + 5'($urandom % 7), 7'b0110111});
         end else if ($urandom % 6 == 0) begin
            prog.push_back(rtype(7'h20, 3'd0, 5'd1 + 5'($urandom % 7),
                                 5'd1 + 5'($urandom % 7), 5'd1 + 5'($urandom % 7)));
         end else begin
            prog.push_back(rtype(7'h00, f3_list[$urandom % 5], 5'd1 + 5'($urandom % 7),
                                 5'd1 + 5'($urandom % 7), 5'd1 + 5'($urandom % 7)));
         end
      end
      for (int r = 1; r < 8; r++) begin
         prog.push_back(stype(r[4:0], 5'd0, 12'h400 + 12'(4 * r)));
      end
      prog.push_back(32'd0);
      load_program();
      run_and_report();
      for (int r = 1; r < 8; r++) begin
         read_word(RAM_BASE + 32'h400 + 4 * r, rdata);
      end
      write_word(32'h0, 32'd0);

      // Array sum with LW and BNE
      for (int i = 0; i < 8; i++) begin
         write_word(RAM_BASE + 32'h500 + 4 * i, $urandom);
      end
      prog.delete();
      prog.push_back(itype(3'd0, 5'd1, 5'd0, 12'h500, 7'b0010011));
      prog.push_back(itype(3'd0, 5'd2, 5'd0, 12'd8, 7'b0010011));
      prog.push_back(itype(3'd0, 5'd3, 5'd0, 12'd0, 7'b0010011));
      prog.push_back(itype(3'b010, 5'd4, 5'd1, 12'd0, 7'b0000011));
      prog.push_back(rtype(7'h00, 3'd0, 5'd3, 5'd3, 5'd4));
      prog.push_back(itype(3'd0, 5'd1, 5'd1, 12'd4, 7'b0010011));
      prog.push_back(itype(3'd0, 5'd2, 5'd2, 12'hfff, 7'b0010011));
      prog.push_back(btype(3'd1, 5'd2, 5'd0, -13'sd16));
      prog.push_back(stype(5'd3, 5'd0, 12'h600));
      prog.push_back(btype(3'd0, 5'd1, 5'd0, 13'd8));
      prog.push_back(stype(5'd1, 5'd0, 12'h604));
      prog.push_back(32'd0);
      load_program();
      run_and_report();
      read_word(RAM_BASE + 32'h600, rdata);
      read_word(RAM_BASE + 32'h604, rdata);
      write_word(32'h0, 32'd0);

      // JAL over code that would corrupt memory
      write_word(RAM_BASE + 32'h700, $urandom);
      prog.delete();
      prog.push_back(itype(3'd0, 5'd5, 5'd0, 12'($urandom), 7'b0010011));
      prog.push_back(jtype(5'd1, 21'd12));
      prog.push_back(stype(5'd5, 5'd0, 12'h700));
      prog.push_back(itype(3'd0, 5'd5, 5'd0, 12'd0, 7'b0010011));
      prog.push_back(stype(5'd1, 5'd0, 12'h704));
      prog.push_back(stype(5'd5, 5'd0, 12'h708));
      prog.push_back(32'd0);
      load_program();
      run_and_report();
      for (int a = 0; a < 12; a += 4) begin
         read_word(RAM_BASE + 32'h700 + a, rdata);
      end

      // Restart after halt
      write_word(32'h0, 32'd0);
      for (int a = 0; a < 16; a += 4) begin
         read_word(a, rdata);
      end
      run_and_report();
      for (int a = 0; a < 12; a += 4) begin
         read_word(RAM_BASE + 32'h700 + a, rdata);
      end
      write_word(32'h0, 32'd0);

      @(negedge clk);
      $display("Errors: %0d compare, %0d protocol", check_errors, host_errors);
      if (check_errors == 0 && host_errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

//--- all.f
cpu_pkg.sv
fetch.sv
regfile.sv
execute.sv
core.sv
dual_port_ram.sv
host_regs.sv
cpu_top.sv
tb_clkgen.sv
tb_checker.sv
tb_top.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_top -o tb_sim &&
./obj_dir/tb_sim > sim.log 2>&1 ||
{ echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1 || exit 0
